// File: project.f
core_pkg.sv
core_decoder.sv
core_regfile.sv
core_alu.sv
core_exu.sv
core_dmem.sv
core_top.sv
tb_core_checker.sv
tb_core.sv

// File: tb_core.sv
`default_nettype none

module tb_core import core_pkg::*; ();

    logic        clk;
    logic        rst_n;
    word_t       instr;
    word_t       pc;
    retire_t     ret;
    logic        halted;
    word_t       halt_code;

    // Program table with one entry per presented instruction
    word_t       instr_tab [$];
    retire_t     exp_tab [$];
    logic        halt_tab [$];
    word_t       code_tab [$];
    word_t       row_pc;

    logic        row_valid;
    logic [15:0] row_idx;
    retire_t     exp_ret;
    logic        exp_halted;
    word_t       exp_code;
    int          rows_checked;
    int          errors;
    int          cycles = 0;
    int          max_cycles;

    core_top u_core_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .pc        (pc),
        .ret       (ret),
        .halted    (halted),
        .halt_code (halt_code)
    );

    tb_core_checker u_tb_core_checker (
        .clk          (clk),
        .row_valid    (row_valid),
        .row_idx      (row_idx),
        .exp_ret      (exp_ret),
        .exp_halted   (exp_halted),
        .exp_code     (exp_code),
        .ret          (ret),
        .pc           (pc),
        .halted       (halted),
        .halt_code    (halt_code),
        .rows_checked (rows_checked),
        .errors       (errors)
    );

    // RV32I instruction encoders
    function automatic word_t enc_r(input int f7, rs2, rs1, f3, rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op_reg};
    endfunction

    function automatic word_t enc_i(input int imm, rs1, f3, rd, input opcode_t op);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic word_t enc_s(input int imm, rs2, rs1, f3);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], op_store};
    endfunction

    function automatic word_t enc_b(input int off, rs1, rs2, f3);
        logic [12:0] v;
        v = 13'(off);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], op_branch};
    endfunction

    function automatic word_t enc_u(input int imm20, rd, input opcode_t op);
        return {20'(imm20), 5'(rd), op};
    endfunction

    function automatic word_t enc_j(input int off, rd);
        logic [20:0] v;
        v = 21'(off);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), op_jal};
    endfunction

    task automatic add_jump(input word_t ins, input logic wb_en, input int rd,
                            input word_t data, input word_t next);
        retire_t r;
        r.valid   = 1'b1;
        r.pc      = row_pc;
        r.wb_en   = wb_en;
        r.wb_addr = 5'(rd);
        r.wb_data = data;
        r.next_pc = next;
        instr_tab.push_back(ins);
        exp_tab.push_back(r);
        halt_tab.push_back(1'b0);
        code_tab.push_back('0);
        row_pc = next;
    endtask

    // Sequential instruction whose next pc is pc plus 4
    task automatic add_row(input word_t ins, input logic wb_en, input int rd, input word_t data);
        add_jump(ins, wb_en, rd, data, row_pc + 32'd4);
    endtask

    // Core already halted so pc stays frozen and nothing retires
    task automatic add_halted(input word_t ins, input word_t code);
        retire_t r;
        r    = '0;
        r.pc = row_pc;
        instr_tab.push_back(ins);
        exp_tab.push_back(r);
        halt_tab.push_back(1'b1);
        code_tab.push_back(code);
    endtask

    task automatic build_table();
        row_pc = reset_pc;
        // Operands x1 = 5 and x2 = -3
        add_row(enc_i(5, 0, 0, 1, op_imm), 1, 1, 32'h0000_0005);
        add_row(enc_i(-3, 0, 0, 2, op_imm), 1, 2, 32'hffff_fffd);
        add_row(enc_r(0, 2, 1, 0, 3), 1, 3, 32'h0000_0002);
        add_row(enc_r(32, 2, 1, 0, 4), 1, 4, 32'h0000_0008);
        add_row(enc_r(0, 1, 2, 2, 5), 1, 5, 32'h0000_0001);
        add_row(enc_r(0, 1, 2, 3, 6), 1, 6, 32'h0000_0000);
        add_row(enc_r(0, 2, 1, 4, 7), 1, 7, 32'hffff_fff8);
        add_row(enc_r(0, 2, 1, 6, 8), 1, 8, 32'hffff_fffd);
        add_row(enc_r(0, 2, 1, 7, 9), 1, 9, 32'h0000_0005);
        add_row(enc_r(0, 3, 1, 1, 10), 1, 10, 32'h0000_0014);
        add_row(enc_r(0, 3, 2, 5, 11), 1, 11, 32'h3fff_ffff);
        add_row(enc_r(32, 3, 2, 5, 12), 1, 12, 32'hffff_ffff);
        add_row(enc_i('h401, 2, 5, 13, op_imm), 1, 13, 32'hffff_fffe);   // srai by 1
        // Upper immediates and a write to x0
        add_row(enc_u('h12345, 14, op_lui), 1, 14, 32'h1234_5000);
        add_row(enc_u('h00001, 15, op_auipc), 1, 15, 32'h8000_1038);
        add_row(enc_u('habcde, 0, op_lui), 1, 0, 32'habcd_e000);
        add_row(enc_r(0, 1, 0, 0, 16), 1, 16, 32'h0000_0005);
        // Branches taken and not taken
        add_jump(enc_b(8, 1, 1, 0), 0, 0, '0, 32'h8000_004c);
        add_jump(enc_b(8, 1, 1, 1), 0, 0, '0, 32'h8000_0050);
        add_jump(enc_b(12, 2, 1, 4), 0, 0, '0, 32'h8000_005c);
        add_jump(enc_b(8, 2, 1, 7), 0, 0, '0, 32'h8000_0064);
        add_jump(enc_b(8, 1, 2, 7), 0, 0, '0, 32'h8000_0068);
        add_jump(enc_b(8, 1, 2, 4), 0, 0, '0, 32'h8000_006c);
        add_jump(enc_b(8, 1, 2, 0), 0, 0, '0, 32'h8000_0070);
        add_jump(enc_b(8, 1, 2, 1), 0, 0, '0, 32'h8000_0078);
        add_jump(enc_j('h14, 17), 1, 17, 32'h8000_007c, 32'h8000_008c);
        add_jump(enc_i('h21, 17, 0, 18, op_jalr), 1, 18, 32'h8000_0090, 32'h8000_009c);
        // Stores merge into the word at 0x100
        add_row(enc_i('h100, 0, 0, 19, op_imm), 1, 19, 32'h0000_0100);
        add_row(enc_u('h89abd, 20, op_lui), 1, 20, 32'h89ab_d000);
        add_row(enc_i(-'h211, 20, 0, 20, op_imm), 1, 20, 32'h89ab_cdef);
        add_row(enc_s(0, 20, 19, 2), 0, 0, '0);
        add_row(enc_i(-'h2bc, 0, 0, 21, op_imm), 1, 21, 32'hffff_fd44);
        add_row(enc_s(2, 21, 19, 1), 0, 0, '0);
        add_row(enc_i('h7e, 0, 0, 22, op_imm), 1, 22, 32'h0000_007e);
        add_row(enc_s(1, 22, 19, 0), 0, 0, '0);
        add_row(enc_i('h90, 0, 0, 23, op_imm), 1, 23, 32'h0000_0090);
        add_row(enc_s(0, 23, 19, 0), 0, 0, '0);
        // Word now reads fd447e90
        add_row(enc_i(0, 19, 2, 24, op_load), 1, 24, 32'hfd44_7e90);
        add_row(enc_i(2, 19, 1, 25, op_load), 1, 25, 32'hffff_fd44);
        add_row(enc_i(2, 19, 5, 26, op_load), 1, 26, 32'h0000_fd44);
        add_row(enc_i(0, 19, 1, 27, op_load), 1, 27, 32'h0000_7e90);
        add_row(enc_i(0, 19, 0, 28, op_load), 1, 28, 32'hffff_ff90);
        add_row(enc_i(0, 19, 4, 29, op_load), 1, 29, 32'h0000_0090);
        add_row(enc_i(1, 19, 0, 30, op_load), 1, 30, 32'h0000_007e);
        add_row(enc_i(3, 19, 4, 31, op_load), 1, 31, 32'h0000_00fd);
        // Halt with a0 = 0x2a
        add_row(enc_i('h2a, 0, 0, 10, op_imm), 1, 10, 32'h0000_002a);
        add_row(enc_i(1, 0, 0, 0, op_system), 0, 0, '0);
        repeat (3) add_halted(enc_i(1, 0, 0, 1, op_imm), 32'h0000_002a);
    endtask

    always begin
        #50;
        clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr      = '0;
        row_valid  = 1'b0;
        row_idx    = '0;
        exp_ret    = '0;
        exp_halted = 1'b0;
        exp_code   = '0;
        build_table();
        max_cycles = 2 * instr_tab.size() + 20;

        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // One row per cycle with the checker looking mid-cycle
        for (int i = 0; i < instr_tab.size(); i++) begin
            instr      = instr_tab[i];
            exp_ret    = exp_tab[i];
            exp_halted = halt_tab[i];
            exp_code   = code_tab[i];
            row_idx    = 16'(i);
            row_valid  = 1'b1;
            @(posedge clk);
            #10;
        end
        row_valid = 1'b0;

        $display("Rows checked %0d of %0d, errors %0d",
                 rows_checked, instr_tab.size(), errors);
        if (errors == 0 && rows_checked == instr_tab.size()) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_core_checker.sv
`default_nettype none

module tb_core_checker import core_pkg::*; (
    input  wire          clk,
    input  wire          row_valid,
    input  wire [15:0]   row_idx,
    input  wire retire_t exp_ret,
    input  wire          exp_halted,
    input  wire word_t   exp_code,
    input  wire retire_t ret,
    input  wire word_t   pc,
    input  wire          halted,
    input  wire word_t   halt_code,
    output int           rows_checked,
    output int           errors
);

    int n_rows = 0;
    int n_errs = 0;
    int row_errs;

    assign rows_checked = n_rows;
    assign errors       = n_errs;

    task automatic compare(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] row %0d %s expected %h got %h", row_idx, name, exp, act);
            row_errs++;
        end
    endtask

    // Inputs change 10 units after the rising edge, so mid-cycle is settled
    always @(negedge clk) begin
        if (row_valid) begin
            row_errs = 0;
            compare("pc", exp_ret.pc, pc);
            compare("ret.valid", 32'(exp_ret.valid), 32'(ret.valid));
            compare("halted", 32'(exp_halted), 32'(halted));
            compare("halt_code", exp_code, halt_code);
            if (exp_ret.valid) begin
                compare("ret.pc", exp_ret.pc, ret.pc);
                compare("ret.wb_en", 32'(exp_ret.wb_en), 32'(ret.wb_en));
                if (exp_ret.wb_en) begin
                    compare("ret.wb_addr", 32'(exp_ret.wb_addr), 32'(ret.wb_addr));
                    compare("ret.wb_data", exp_ret.wb_data, ret.wb_data);
                end
                compare("ret.next_pc", exp_ret.next_pc, ret.next_pc);
            end
            n_rows++;
            n_errs += row_errs;
            if (row_errs == 0) begin
                $display("row %0d pc %h ok", row_idx, exp_ret.pc);
            end else begin
                $display("row %0d pc %h has %0d mismatches", row_idx, exp_ret.pc, row_errs);
            end
        end
    end

endmodule

`default_nettype wire

// File: core_top.sv
`default_nettype none

module core_top import core_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire word_t instr,
    output word_t      pc,
    output retire_t    ret,
    output logic       halted,
    output word_t      halt_code
);

    ctrl_t      ctrl;
    word_t      imm;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_addr;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      a0;
    word_t      mem_addr;
    word_t      mem_wdata;
    word_t      mem_rdata;
    byte_mask_t exu_wmask;
    byte_mask_t mem_wmask;
    word_t      wb_data;
    word_t      next_pc;
    logic       run;
    logic       rf_we;

    assign run       = !halted;
    assign rf_we     = ctrl.wb_en && run;
    assign mem_wmask = run ? exu_wmask : '0;

    core_decoder u_core_decoder (
        .instr    (instr),
        .ctrl     (ctrl),
        .imm      (imm),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr)
    );

    core_regfile u_core_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd_addr  (rd_addr),
        .rd_data  (wb_data),
        .a0       (a0)
    );

    core_exu u_core_exu (
        .ctrl      (ctrl),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (exu_wmask),
        .mem_rdata (mem_rdata),
        .wb_data   (wb_data),
        .next_pc   (next_pc)
    );

    core_dmem u_core_dmem (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .wmask (mem_wmask),
        .rdata (mem_rdata)
    );

    // pc advances on every retire, ebreak included, then freezes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= reset_pc;
            halted    <= 1'b0;
            halt_code <= '0;
        end else if (run) begin
            pc <= next_pc;
            if (ctrl.is_ebreak) begin
                halted    <= 1'b1;
                halt_code <= a0;
            end
        end
    end

    always_comb begin
        ret.valid   = run;
        ret.pc      = pc;
        ret.wb_en   = rf_we;
        ret.wb_addr = rd_addr;
        ret.wb_data = wb_data;
        ret.next_pc = next_pc;
    end

endmodule

`default_nettype wire

// File: core_dmem.sv
`default_nettype none

module core_dmem import core_pkg::*; (
    input  wire             clk,
    input  wire word_t      addr,
    input  wire word_t      wdata,
    input  wire byte_mask_t wmask,
    output word_t           rdata
);

    word_t                 mem [dmem_words];
    logic [dmem_idx_w-1:0] idx;

    // Word index from the bits above bit 1 with the upper bits wrapping
    assign idx = addr[dmem_idx_w+1:2];

    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wmask[lane]) begin
                mem[idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: core_exu.sv
`default_nettype none

module core_exu import core_pkg::*; (
    input  wire ctrl_t ctrl,
    input  wire word_t pc,
    input  wire word_t rs1_data,
    input  wire word_t rs2_data,
    input  wire word_t imm,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    output byte_mask_t mem_wmask,
    input  wire word_t mem_rdata,
    output word_t      wb_data,
    output word_t      next_pc
);

    word_t opa;
    word_t opb;
    word_t alu_res;
    word_t pc4;
    word_t target_base;
    word_t target;
    logic  br_cond;
    logic  br_taken;
    logic  [4:0] lane_shift;
    word_t rdata_shifted;
    word_t load_data;

    always_comb begin
        case (ctrl.opa_sel)
            opa_rs1: opa = rs1_data;
            opa_pc:  opa = pc;
            default: opa = '0;
        endcase
    end

    assign opb = (ctrl.opb_sel == opb_rs2) ? rs2_data : imm;

    core_alu u_core_alu (
        .op  (ctrl.alu_op),
        .a   (opa),
        .b   (opb),
        .res (alu_res)
    );

    // Branch compare kept apart from the ALU
    assign br_cond = (ctrl.br_eq && (rs1_data == rs2_data))
                   || (ctrl.br_lt && ctrl.br_unsigned && (rs1_data < rs2_data))
                   || (ctrl.br_lt && !ctrl.br_unsigned
                       && ($signed(rs1_data) < $signed(rs2_data)));
    assign br_taken = br_cond ^ ctrl.br_invert;

    // Next pc
    assign pc4         = pc + 32'd4;
    assign target_base = (ctrl.pc_sel == pc_jalr) ? rs1_data : pc;
    assign target      = target_base + imm;

    always_comb begin
        case (ctrl.pc_sel)
            pc_branch: next_pc = br_taken ? target : pc4;
            pc_jal:    next_pc = target;
            pc_jalr:   next_pc = {target[31:1], 1'b0};
            default:   next_pc = pc4;
        endcase
    end

    // Store data moved up to its byte lane
    assign mem_addr   = alu_res;
    assign lane_shift = {mem_addr[1:0], 3'b000};
    assign mem_wdata  = rs2_data << lane_shift;

    always_comb begin
        mem_wmask = '0;
        if (ctrl.mem_write) begin
            case (ctrl.mem_size)
                mem_byte: mem_wmask = 4'b0001 << mem_addr[1:0];
                mem_half: mem_wmask = mem_addr[1] ? 4'b1100 : 4'b0011;
                mem_word: mem_wmask = 4'b1111;
                default:  mem_wmask = '0;
            endcase
        end
    end

    // Load side
    assign rdata_shifted = mem_rdata >> lane_shift;

    always_comb begin
        case (ctrl.mem_size)
            mem_byte: load_data = {{24{rdata_shifted[7] & ctrl.load_signed}},
                                   rdata_shifted[7:0]};
            mem_half: load_data = {{16{rdata_shifted[15] & ctrl.load_signed}},
                                   rdata_shifted[15:0]};
            default:  load_data = rdata_shifted;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = load_data;
            wb_pc4:  wb_data = pc4;
            default: wb_data = alu_res;
        endcase
    end

endmodule

`default_nettype wire

// File: core_alu.sv
`default_nettype none

module core_alu import core_pkg::*; (
    input  wire alu_op_e op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        res
);

    logic        sub_en;
    word_t       b_in;
    logic [32:0] sum;
    logic        lt_s;
    logic        lt_u;
    logic [4:0]  shamt;

    // One adder does add, sub and both compares
    assign sub_en = (op == alu_sub) || (op == alu_slt) || (op == alu_sltu);
    assign b_in   = sub_en ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_in} + 33'(sub_en);

    // No carry out of a - b means a borrow
    assign lt_u = !sum[32];
    assign lt_s = (a[31] ^ b[31]) ? a[31] : sum[31];

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add, alu_sub: res = sum[31:0];
            alu_sll:          res = a << shamt;
            alu_slt:          res = {31'b0, lt_s};
            alu_sltu:         res = {31'b0, lt_u};
            alu_xor:          res = a ^ b;
            alu_srl:          res = a >> shamt;
            alu_sra:          res = word_t'($signed(a) >>> shamt);
            alu_or:           res = a | b;
            alu_and:          res = a & b;
            alu_pass_b:       res = b;
            default:          res = sum[31:0];
        endcase
    end

endmodule

`default_nettype wire

// File: core_regfile.sv
`default_nettype none

module core_regfile import core_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire reg_addr_t rs1_addr,
    input  wire reg_addr_t rs2_addr,
    output word_t          rs1_data,
    output word_t          rs2_data,
    input  wire            we,
    input  wire reg_addr_t rd_addr,
    input  wire word_t     rd_data,
    output word_t          a0
);

    // x0 has no storage
    word_t regs [1:31];
    logic  wr_en;

    // No writes while the core sits in reset
    assign wr_en = we && rst_n && (rd_addr != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    assign a0 = regs[10];

endmodule

`default_nettype wire

// File: core_decoder.sv
`default_nettype none

module core_decoder import core_pkg::*; (
    input  wire word_t instr,
    output ctrl_t      ctrl,
    output word_t      imm,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    output reg_addr_t  rd_addr
);

    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // Shared by register and immediate arithmetic
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub_or_sra);
        case (f3)
            3'b000:  return sub_or_sra ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return sub_or_sra ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign funct3   = instr[14:12];
    assign alt      = instr[30];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Defaults describe a no-op
        ctrl             = '0;
        ctrl.alu_op      = alu_add;
        ctrl.opa_sel     = opa_zero;
        ctrl.opb_sel     = opb_imm;
        ctrl.pc_sel      = pc_plus4;
        ctrl.mem_size    = mem_none;
        ctrl.wb_sel      = wb_alu;
        imm              = imm_i;

        case (instr[6:0])
            op_lui: begin
                ctrl.alu_op = alu_pass_b;
                ctrl.wb_en  = 1'b1;
                imm         = imm_u;
            end
            op_auipc: begin
                ctrl.opa_sel = opa_pc;
                ctrl.wb_en   = 1'b1;
                imm          = imm_u;
            end
            op_jal: begin
                ctrl.pc_sel = pc_jal;
                ctrl.wb_sel = wb_pc4;
                ctrl.wb_en  = 1'b1;
                imm         = imm_j;
            end
            op_jalr: begin
                ctrl.pc_sel = pc_jalr;
                ctrl.wb_sel = wb_pc4;
                ctrl.wb_en  = 1'b1;
            end
            op_branch: begin
                ctrl.opa_sel     = opa_rs1;
                ctrl.opb_sel     = opb_rs2;
                ctrl.alu_op      = alu_sub;
                ctrl.pc_sel      = pc_branch;
                ctrl.br_eq       = !funct3[2];
                ctrl.br_lt       = funct3[2];
                ctrl.br_unsigned = funct3[1];
                ctrl.br_invert   = funct3[0];
                imm              = imm_b;
            end
            op_load, op_store: begin
                ctrl.opa_sel = opa_rs1;
                case (funct3[1:0])
                    2'b00:   ctrl.mem_size = mem_byte;
                    2'b01:   ctrl.mem_size = mem_half;
                    default: ctrl.mem_size = mem_word;
                endcase
                if (instr[5]) begin
                    ctrl.mem_write = 1'b1;
                    imm            = imm_s;
                end else begin
                    ctrl.load_signed = !funct3[2];
                    ctrl.wb_sel      = wb_mem;
                    ctrl.wb_en       = 1'b1;
                end
            end
            op_imm: begin
                ctrl.opa_sel = opa_rs1;
                // Only srai uses bit 30 among immediate forms
                ctrl.alu_op  = alu_from_funct(funct3, alt && (funct3 == 3'b101));
                ctrl.wb_en   = 1'b1;
            end
            op_reg: begin
                ctrl.opa_sel = opa_rs1;
                ctrl.opb_sel = opb_rs2;
                ctrl.alu_op  = alu_from_funct(funct3, alt);
                ctrl.wb_en   = 1'b1;
            end
            op_system: begin
                ctrl.is_ebreak = (instr[31:7] == 25'h0002000);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_mask_t;
    typedef logic [6:0]  opcode_t;

    localparam word_t reset_pc   = 32'h8000_0000;
    localparam int    dmem_words = 1024;
    localparam int    dmem_idx_w = $clog2(dmem_words);

    // RV32I major opcodes
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_system = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {opa_rs1, opa_pc, opa_zero} opa_sel_e;
    typedef enum logic {opb_rs2, opb_imm} opb_sel_e;

    typedef enum logic [1:0] {pc_plus4, pc_branch, pc_jal, pc_jalr} pc_sel_e;

    typedef enum logic [1:0] {mem_none, mem_byte, mem_half, mem_word} mem_size_e;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        pc_sel_e   pc_sel;
        logic      br_eq;
        logic      br_lt;
        logic      br_unsigned;
        logic      br_invert;
        mem_size_e mem_size;
        logic      mem_write;
        logic      load_signed;
        wb_sel_e   wb_sel;
        logic      wb_en;
        logic      is_ebreak;
    } ctrl_t;

    // One retired instruction, as seen from outside the core
    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      wb_en;
        reg_addr_t wb_addr;
        word_t     wb_data;
        word_t     next_pc;
    } retire_t;

endpackage

`default_nettype wire
